// ==== sim/aes_cases.txt ====
// Per frame: payload count, command (bit 0 = CBC), key, payload blocks, expected ciphertexts
// A zero count ends the list
// FIPS-197 AES-128 in ECB
1 0
000102030405060708090a0b0c0d0e0f
00112233445566778899aabbccddeeff
69c4e0d86a7b0430d8cdb78070b4c55a
// SP800-38A CBC, IV first
5 1
2b7e151628aed2a6abf7158809cf4f3c
000102030405060708090a0b0c0d0e0f
6bc1bee22e409f96e93d7e117393172a ae2d8a571e03ac9c9eb76fac45af8e51
30c81c46a35ce411e5fbc1191a0a52ef f69f2445df4f9b17ad2b417be66c3710
7649abac8119b246cee98e9b12e9197d 5086cb9b507219ee95db113a917678b2
73bed6b8e3c1743b7116e69e22229516 3ff1caa1681fac09120eca307586e1a7
// SP800-38A ECB
4 0
2b7e151628aed2a6abf7158809cf4f3c
6bc1bee22e409f96e93d7e117393172a ae2d8a571e03ac9c9eb76fac45af8e51
30c81c46a35ce411e5fbc1191a0a52ef f69f2445df4f9b17ad2b417be66c3710
3ad77bb40d7a3660a89ecaf32466ef97 f5d3d58503b9699de785895a96fdbaaf
43b1cd7f598ece23881b00e3ed030688 7b0c785e27e8ad3f8223207104725dd4
0

// ==== all.f ====
+incdir+hdl
hdl/aes_ctrl_pkg.sv
hdl/aes_cmd_decode.sv
hdl/aes_round_core.sv
hdl/aes_mode_execute.sv
hdl/aes_result_stage.sv
hdl/aes_controller_top.sv
sim/aes_controller_tb.sv

// ==== Bender.yml ====
package:
  name: aes_controller

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aes_ctrl_pkg.sv
      - hdl/aes_cmd_decode.sv
      - hdl/aes_round_core.sv
      - hdl/aes_mode_execute.sv
      - hdl/aes_result_stage.sv
      - hdl/aes_controller_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/aes_controller_tb.sv

// ==== sim/aes_controller_tb.sv ====
`timescale 1ns/1ps
`include "aes_ctrl_cfg.svh"

module aes_controller_tb import aes_ctrl_pkg::*; ();

	localparam int IN_CREDITS = `AES_IN_CREDITS;
	localparam int OUT_CREDITS = `AES_OUT_CREDITS;
	localparam int MEM_WORDS = 64;

	logic aes_clk;
	logic aes_reset;
	logic in_valid = 1'b0;
	beat_t in_beat = '0;
	logic in_credit;
	logic out_valid;
	beat_t out_beat;
	logic out_credit = 1'b0;

	logic [127:0] cases_mem [MEM_WORDS];
	beat_t in_beats [$];
	beat_t exp_beats [$];
	int in_count;
	int exp_count;
	int src_idx;
	int src_credits;
	int out_idx;
	int sink_held;
	int cycle_count = 0;
	int cycle_limit;
	logic src_send;
	logic sink_ret;
	logic [5:0] sink_wait;
	logic [31:0] rng_state;
	logic [31:0] rng_next;

	aes_controller_top dut_i (
		.aes_clk(aes_clk), .aes_reset(aes_reset),
		.in_valid(in_valid), .in_beat(in_beat), .in_credit(in_credit),
		.out_valid(out_valid), .out_beat(out_beat), .out_credit(out_credit)
	);

	// ==============================
	// Helpers
	// ==============================
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [128:0] got,
			input logic [128:0] exp);
		if (got !== exp)
			stop_on_failure($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Each frame holds count, command, key, payload blocks and expected blocks
	task automatic load_cases();
		int pos;
		int count;
		int n_exp;
		logic [127:0] cmd;
		pos = 0;
		$readmemh("sim/aes_cases.txt", cases_mem);
		while (pos < MEM_WORDS - 3 && cases_mem[pos] !== '0) begin
			count = int'(cases_mem[pos]);
			cmd = cases_mem[pos + 1];
			in_beats.push_back('{last: 1'b0, data: cmd});
			in_beats.push_back('{last: 1'b0, data: cases_mem[pos + 2]});
			pos = pos + 3;
			for (int i = 0; i < count; i++)
				in_beats.push_back('{last: (i == count - 1), data: cases_mem[pos + i]});
			pos = pos + count;
			// CBC spends its first block on the IV
			n_exp = cmd[0] ? count - 1 : count;
			for (int i = 0; i < n_exp; i++)
				exp_beats.push_back('{last: (i == n_exp - 1), data: cases_mem[pos + i]});
			pos = pos + n_exp;
		end
		in_count = in_beats.size();
		exp_count = exp_beats.size();
		if (in_count == 0)
			stop_on_failure("No frames found in sim/aes_cases.txt");
	endtask

	// ==============================
	// Clock, reset and run control
	// ==============================
	initial begin
		aes_clk = 1'b0;
		forever #50 aes_clk = ~aes_clk;
	end

	initial begin
		aes_reset <= 1'b1;
		load_cases();
		cycle_limit = 40 * in_count + 200;
		repeat (10) @(posedge aes_clk);
		aes_reset <= 1'b0;
		wait (out_idx == exp_count);
		// Last input credit comes back a cycle after its pop
		while (src_credits != IN_CREDITS)
			@(posedge aes_clk);
		$display("TEST PASSED");
		$finish;
	end

	always @(posedge aes_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			stop_on_failure($sformatf("Timeout after %0d cycles with %0d of %0d beats out",
				cycle_count, out_idx, exp_count));
	end

	// ==============================
	// Source
	// ==============================
	assign src_send = !aes_reset && (src_credits != 0) && (src_idx < in_count);

	always @(posedge aes_clk) begin
		if (aes_reset) begin
			in_valid <= 1'b0;
			src_idx <= 0;
			src_credits <= IN_CREDITS;
		end else begin
			if (in_credit && src_credits == IN_CREDITS)
				stop_on_failure("Input credit returned with no beat outstanding");
			in_valid <= src_send;
			if (src_send) begin
				in_beat <= in_beats[src_idx];
				src_idx <= src_idx + 1;
			end
			src_credits <= src_credits + int'(in_credit) - int'(src_send);
		end
	end

	// ==============================
	// Sink with random credit delay
	// ==============================
	assign sink_ret = (sink_held != 0) && (sink_wait == '0);
	assign rng_next = lcg_next(rng_state);

	always @(posedge aes_clk) begin
		if (aes_reset) begin
			out_credit <= 1'b0;
			sink_held <= 0;
			sink_wait <= '0;
			rng_state <= 32'h9f59;
			out_idx <= 0;
		end else begin
			if (out_valid) begin
				if (sink_held == OUT_CREDITS)
					stop_on_failure("out_valid pulsed while no output credit was left");
				if (out_idx >= exp_count)
					stop_on_failure("Output beat arrived beyond the expected ones");
				check_value("out_beat.data", out_beat.data, exp_beats[out_idx].data);
				check_value("out_beat.last", out_beat.last, exp_beats[out_idx].last);
				out_idx <= out_idx + 1;
			end
			out_credit <= sink_ret;
			if (sink_ret) begin
				sink_wait <= rng_next[21:16];
				rng_state <= rng_next;
			end else if (sink_wait != '0) begin
				sink_wait <= sink_wait - 1'b1;
			end
			sink_held <= sink_held + int'(out_valid) - int'(sink_ret);
		end
	end

endmodule

// ==== hdl/aes_controller_top.sv ====
`timescale 1ns/1ps

module aes_controller_top import aes_ctrl_pkg::*; (
	input  logic  aes_clk,
	input  logic  aes_reset,
	input  logic  in_valid,
	input  beat_t in_beat,
	output logic  in_credit,
	output logic  out_valid,
	output beat_t out_beat,
	input  logic  out_credit
);

	logic pay_valid;
	logic pay_take;
	beat_t pay_beat;
	chain_e mode;
	key_t key;
	logic frame_done;
	logic frame_end;
	logic core_start;
	logic core_busy;
	logic core_done;
	blk_t core_blk;
	blk_t core_result;
	logic slot_free;
	logic res_valid;
	beat_t res_beat;

	// ==============================
	// Front end and chaining
	// ==============================
	aes_cmd_decode decode_i (
		.aes_clk(aes_clk), .aes_reset(aes_reset),
		.in_valid(in_valid), .in_beat(in_beat), .in_credit(in_credit),
		.pay_valid(pay_valid), .pay_beat(pay_beat), .pay_take(pay_take),
		.mode(mode), .key(key), .frame_done(frame_done)
	);

	aes_mode_execute execute_i (
		.aes_clk(aes_clk), .aes_reset(aes_reset),
		.pay_valid(pay_valid), .pay_beat(pay_beat), .pay_take(pay_take),
		.mode(mode), .key(key), .frame_done(frame_done),
		.core_start(core_start), .core_blk(core_blk), .core_busy(core_busy),
		.core_done(core_done), .core_result(core_result),
		.slot_free(slot_free), .res_valid(res_valid), .res_beat(res_beat),
		.frame_end(frame_end)
	);

	// ==============================
	// Cipher and output
	// ==============================
	aes_round_core core_i (
		.aes_clk(aes_clk), .aes_reset(aes_reset),
		.start(core_start), .blk_in(core_blk), .key(key),
		.busy(core_busy), .done(core_done), .blk_out(core_result)
	);

	aes_result_stage result_i (
		.aes_clk(aes_clk), .aes_reset(aes_reset),
		.res_valid(res_valid), .res_beat(res_beat), .slot_free(slot_free),
		.out_valid(out_valid), .out_beat(out_beat), .out_credit(out_credit),
		.frame_end(frame_end)
	);

endmodule

// ==== hdl/aes_result_stage.sv ====
`timescale 1ns/1ps
`include "aes_ctrl_cfg.svh"

module aes_result_stage import aes_ctrl_pkg::*; (
	input  logic  aes_clk,
	input  logic  aes_reset,
	input  logic  res_valid,
	input  beat_t res_beat,
	output logic  slot_free,
	output logic  out_valid,
	output beat_t out_beat,
	input  logic  out_credit,
	output logic  frame_end
);

	logic slot_full;
	beat_t slot;
	credit_t credits;
	logic send;

	assign slot_free = !slot_full;
	assign send = slot_full && (credits != '0);
	assign frame_end = out_valid && out_beat.last;

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			slot_full <= 1'b0;
			out_valid <= 1'b0;
			credits <= credit_t'(`AES_OUT_CREDITS);
		end else begin
			out_valid <= send;
			if (res_valid)
				slot_full <= 1'b1;
			else if (send)
				slot_full <= 1'b0;
			// Spend on send, refill on the sink's return pulse
			if (send && !out_credit)
				credits <= credits - 1'b1;
			else if (!send && out_credit)
				credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge aes_clk) begin
		if (res_valid)
			slot <= res_beat;
		if (send)
			out_beat <= slot;
	end

endmodule

// ==== hdl/aes_mode_execute.sv ====
`timescale 1ns/1ps

module aes_mode_execute import aes_ctrl_pkg::*; (
	input  logic   aes_clk,
	input  logic   aes_reset,
	input  logic   pay_valid,
	input  beat_t  pay_beat,
	output logic   pay_take,
	input  chain_e mode,
	input  key_t   key,
	output logic   frame_done,
	output logic   core_start,
	output blk_t   core_blk,
	input  logic   core_busy,
	input  logic   core_done,
	input  blk_t   core_result,
	input  logic   slot_free,
	output logic   res_valid,
	output beat_t  res_beat,
	input  logic   frame_end
);

	logic first_blk;
	logic iv_take;
	logic blk_last;
	blk_t chain;

	// One block in flight, so the slot is still free when its done arrives
	assign pay_take = pay_valid && !core_busy && !core_done && slot_free;
	assign iv_take = pay_take && first_blk && (mode == CBC);
	assign core_start = pay_take && !iv_take;
	assign core_blk = (mode == CBC) ? (pay_beat.data ^ chain) : pay_beat.data;

	assign res_valid = core_done;
	assign res_beat = '{last: blk_last, data: core_result};
	assign frame_done = frame_end;

	always_ff @(posedge aes_clk) begin
		if (aes_reset)
			first_blk <= 1'b1;
		else if (frame_end)
			first_blk <= 1'b1;
		else if (pay_take)
			first_blk <= 1'b0;
	end

	// IV first, then each ciphertext becomes the chain value
	always_ff @(posedge aes_clk) begin
		if (iv_take)
			chain <= pay_beat.data;
		else if (core_done)
			chain <= core_result;
		if (core_start)
			blk_last <= pay_beat.last;
	end

endmodule

// ==== hdl/aes_round_core.sv ====
`timescale 1ns/1ps
`include "aes_ctrl_cfg.svh"

module aes_round_core import aes_ctrl_pkg::*; (
	input  logic aes_clk,
	input  logic aes_reset,
	input  logic start,
	input  blk_t blk_in,
	input  key_t key,
	output logic busy,
	output logic done,
	output blk_t blk_out
);

	// ==============================
	// GF(2^8) helpers
	// ==============================
	function automatic logic [7:0] xtime(input logic [7:0] a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ x;
			x = xtime(x);
		end
		return p;
	endfunction

	// Inverse as a^254, zero maps to zero
	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] p;
		logic [7:0] b;
		p = a;
		b = 8'h01;
		for (int i = 1; i < 8; i++) begin
			p = gf_mul(p, p);
			b = gf_mul(b, p);
		end
		// Affine map
		return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^
			{b[3:0], b[7:4]} ^ 8'h63;
	endfunction

	// Byte i of the state is row i%4, column i/4
	function automatic blk_t sub_shift(input blk_t s);
		blk_t o;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				o[127-8*(r+4*c) -: 8] = sbox(s[127-8*(r+4*((c+r)%4)) -: 8]);
		end
		return o;
	endfunction

	function automatic blk_t mix_cols(input blk_t s);
		blk_t o;
		logic [7:0] b0, b1, b2, b3;
		for (int c = 0; c < 4; c++) begin
			b0 = s[127-32*c -: 8];
			b1 = s[119-32*c -: 8];
			b2 = s[111-32*c -: 8];
			b3 = s[103-32*c -: 8];
			o[127-32*c -: 8] = xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3;
			o[119-32*c -: 8] = b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3;
			o[111-32*c -: 8] = b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3;
			o[103-32*c -: 8] = xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3);
		end
		return o;
	endfunction

	// One step of the AES-128 schedule
	function automatic key_t key_step(input key_t k, input logic [7:0] rc);
		logic [31:0] t;
		key_t o;
		t = {sbox(k[23:16]), sbox(k[15:8]), sbox(k[7:0]), sbox(k[31:24])};
		t[31:24] = t[31:24] ^ rc;
		o[127:96] = k[127:96] ^ t;
		o[95:64] = k[95:64] ^ o[127:96];
		o[63:32] = k[63:32] ^ o[95:64];
		o[31:0] = k[31:0] ^ o[63:32];
		return o;
	endfunction

	// ==============================
	// Round datapath
	// ==============================
	blk_t state;
	key_t round_key;
	key_t key_next;
	logic [7:0] rcon;
	round_t round;
	blk_t shifted;
	logic last_round;

	assign last_round = (round == round_t'(`AES_ROUNDS));
	assign key_next = key_step(round_key, rcon);
	assign shifted = sub_shift(state);
	assign blk_out = state;

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			round <= '0;
		end else begin
			done <= busy && last_round;
			if (start && !busy) begin
				busy <= 1'b1;
				round <= round_t'(1);
			end else if (busy) begin
				busy <= !last_round;
				round <= last_round ? '0 : round + 1'b1;
			end
		end
	end

	always_ff @(posedge aes_clk) begin
		if (start && !busy) begin
			state <= blk_in ^ key;
			round_key <= key;
			rcon <= 8'h01;
		end else if (busy) begin
			// No MixColumns in the final round
			state <= (last_round ? shifted : mix_cols(shifted)) ^ key_next;
			round_key <= key_next;
			rcon <= xtime(rcon);
		end
	end

endmodule

// ==== hdl/aes_cmd_decode.sv ====
`timescale 1ns/1ps
`include "aes_ctrl_cfg.svh"

module aes_cmd_decode import aes_ctrl_pkg::*; (
	input  logic   aes_clk,
	input  logic   aes_reset,
	input  logic   in_valid,
	input  beat_t  in_beat,
	output logic   in_credit,
	output logic   pay_valid,
	output beat_t  pay_beat,
	input  logic   pay_take,
	output chain_e mode,
	output key_t   key,
	input  logic   frame_done
);

	localparam int DEPTH = `AES_IN_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	beat_t buffer [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t fill;
	decode_state_e state;
	logic tail_seen;
	logic has_beat;
	logic pop;
	beat_t head;
	cmd_t cmd;

	// ==============================
	// Input buffer
	// ==============================
	assign has_beat = (fill != '0);
	assign head = buffer[rd_ptr];
	assign cmd = head.data[`AES_CMD_W-1:0];

	always_ff @(posedge aes_clk) begin
		if (in_valid)
			buffer[wr_ptr] <= in_beat;
	end

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (in_valid && !pop)
				fill <= fill + 1'b1;
			else if (!in_valid && pop)
				fill <= fill - 1'b1;
			// One credit back per popped entry
			in_credit <= pop;
		end
	end

	// ==============================
	// Frame FSM
	// ==============================

	// Hold off once the last payload beat is gone, the next command may be queued
	assign pay_valid = (state == PAYLOAD) && has_beat && !tail_seen;
	assign pay_beat = head;

	always_comb begin
		case (state)
			GET_CMD, GET_KEY: pop = has_beat;
			PAYLOAD:          pop = pay_take;
			default:          pop = 1'b0;
		endcase
	end

	always_ff @(posedge aes_clk) begin
		if (aes_reset) begin
			state <= GET_CMD;
			mode <= ECB;
			tail_seen <= 1'b0;
		end else begin
			case (state)
				GET_CMD: if (has_beat) begin
					mode <= chain_e'(cmd[0]);
					state <= GET_KEY;
				end
				GET_KEY: if (has_beat) begin
					tail_seen <= 1'b0;
					state <= PAYLOAD;
				end
				PAYLOAD: begin
					if (pay_take && head.last)
						tail_seen <= 1'b1;
					if (frame_done)
						state <= GET_CMD;
				end
				default: state <= GET_CMD;
			endcase
		end
	end

	always_ff @(posedge aes_clk) begin
		if (state == GET_KEY && has_beat)
			key <= key_t'(head.data);
	end

endmodule

// ==== hdl/aes_ctrl_pkg.sv ====
`include "aes_ctrl_cfg.svh"

package aes_ctrl_pkg;

	// ==============================
	// Vector types
	// ==============================
	typedef logic [`AES_BLK_W-1:0] blk_t;
	typedef logic [`AES_KEY_W-1:0] key_t;
	typedef logic [`AES_CMD_W-1:0] cmd_t;

	// Round index, 0 when idle
	typedef logic [3:0] round_t;

	// Enough for either credit pool
	typedef logic [2:0] credit_t;

	// ==============================
	// Beat and state types
	// ==============================

	// Input beats, payload blocks and output beats
	typedef struct packed {
		logic last;
		blk_t data;
	} beat_t;

	typedef enum logic {
		ECB = 1'b0,
		CBC = 1'b1
	} chain_e;

	typedef enum logic [1:0] {
		GET_CMD,
		GET_KEY,
		PAYLOAD
	} decode_state_e;

endpackage

// ==== hdl/aes_ctrl_cfg.svh ====
`ifndef AES_CTRL_CFG_SVH
`define AES_CTRL_CFG_SVH

// Data path widths
`define AES_BLK_W 128
`define AES_KEY_W 128

// Command field in the low bits of the command beat, bit 0 selects CBC
`define AES_CMD_W 32

// AES-128 round count
`define AES_ROUNDS 10

// Input buffer depth, equal to the source's starting credits
`define AES_IN_CREDITS 2

// Sink buffer size, equal to our starting output credits
`define AES_OUT_CREDITS 4

`endif
